// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
TOP       ?= armTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf $(BUILD_DIR)

// File: arm.sv
`timescale 1ns/1ns
`default_nettype none

module arm #(
  parameter armPkg::word_t resetPc = 32'h0000_0000
) (
  input  logic          clk,
  input  logic          rstN,
  input  armPkg::word_t instruction,
  input  armPkg::word_t readData,
  output armPkg::word_t pc,
  output armPkg::word_t dataAddr,
  output armPkg::word_t writeData,
  output logic          writeEnable
);
  import armPkg::*;

  // Fetch to decode
  word_t    instrD;
  word_t    pcPlus8D;

  // Decode to execute
  aluOp_t   aluOpE;
  logic     aluSrcE;
  logic     setFlagsE;
  logic     regWriteE;
  logic     memWriteE;
  logic     memToRegE;
  logic     branchE;
  cond_t    condE;
  word_t    rdAE;
  word_t    rdBE;
  word_t    immE;
  regAddr_t destE;

  // Branch redirect, also flushes decode
  logic     branchTakenE;
  word_t    branchTargetE;

  // Execute to memory
  word_t    aluOutM;
  word_t    writeDataM;
  regAddr_t destM;
  logic     regWriteM;
  logic     memWriteM;
  logic     memToRegM;

  // Writeback into the register file
  logic     regWriteW;
  regAddr_t destW;
  word_t    resultW;

  fetch #(.resetPc(resetPc)) stageFetch (
    .clk          (clk),
    .rstN         (rstN),
    .branchTakenE (branchTakenE),
    .branchTargetE(branchTargetE),
    .instruction  (instruction),
    .pc           (pc),
    .instrD       (instrD),
    .pcPlus8D     (pcPlus8D)
  );

  decode stageDecode (
    .clk      (clk),
    .rstN     (rstN),
    .flushE   (branchTakenE),
    .instrD   (instrD),
    .pcPlus8D (pcPlus8D),
    .regWriteW(regWriteW),
    .destW    (destW),
    .resultW  (resultW),
    .aluOpE   (aluOpE),
    .aluSrcE  (aluSrcE),
    .setFlagsE(setFlagsE),
    .regWriteE(regWriteE),
    .memWriteE(memWriteE),
    .memToRegE(memToRegE),
    .branchE  (branchE),
    .condE    (condE),
    .rdAE     (rdAE),
    .rdBE     (rdBE),
    .immE     (immE),
    .destE    (destE)
  );

  execute stageExecute (
    .clk          (clk),
    .rstN         (rstN),
    .aluOpE       (aluOpE),
    .aluSrcE      (aluSrcE),
    .setFlagsE    (setFlagsE),
    .regWriteE    (regWriteE),
    .memWriteE    (memWriteE),
    .memToRegE    (memToRegE),
    .branchE      (branchE),
    .condE        (condE),
    .rdAE         (rdAE),
    .rdBE         (rdBE),
    .immE         (immE),
    .destE        (destE),
    .branchTakenE (branchTakenE),
    .branchTargetE(branchTargetE),
    .aluOutM      (aluOutM),
    .writeDataM   (writeDataM),
    .destM        (destM),
    .regWriteM    (regWriteM),
    .memWriteM    (memWriteM),
    .memToRegM    (memToRegM)
  );

  memory stageMemory (
    .clk        (clk),
    .rstN       (rstN),
    .aluOutM    (aluOutM),
    .writeDataM (writeDataM),
    .destM      (destM),
    .regWriteM  (regWriteM),
    .memWriteM  (memWriteM),
    .memToRegM  (memToRegM),
    .readData   (readData),
    .dataAddr   (dataAddr),
    .writeData  (writeData),
    .writeEnable(writeEnable),
    .regWriteW  (regWriteW),
    .destW      (destW),
    .resultW    (resultW)
  );

endmodule

`default_nettype wire

// File: armPkg.sv
`default_nettype none

package armPkg;

  // Datapath widths
  typedef logic [31:0] word_t;
  typedef logic [3:0]  regAddr_t;

  // NZCV with N in bit 3
  typedef logic [3:0]  flags_t;
  typedef logic [3:0]  cond_t;
  typedef logic [2:0]  aluOp_t;

  // ARM condition field encodings
  localparam cond_t EQ = 4'h0;
  localparam cond_t NE = 4'h1;
  localparam cond_t CS = 4'h2;
  localparam cond_t CC = 4'h3;
  localparam cond_t MI = 4'h4;
  localparam cond_t PL = 4'h5;
  localparam cond_t VS = 4'h6;
  localparam cond_t VC = 4'h7;
  localparam cond_t HI = 4'h8;
  localparam cond_t LS = 4'h9;
  localparam cond_t GE = 4'hA;
  localparam cond_t LT = 4'hB;
  localparam cond_t GT = 4'hC;
  localparam cond_t LE = 4'hD;
  localparam cond_t AL = 4'hE;

  // Internal ALU operations
  localparam aluOp_t aluAdd = 3'd0;
  localparam aluOp_t aluSub = 3'd1;
  localparam aluOp_t aluAnd = 3'd2;
  localparam aluOp_t aluOrr = 3'd3;
  localparam aluOp_t aluMov = 3'd4;

  // Data processing opcode field, bits 24:21
  localparam logic [3:0] opAnd = 4'b0000;
  localparam logic [3:0] opSub = 4'b0010;
  localparam logic [3:0] opAdd = 4'b0100;
  localparam logic [3:0] opOrr = 4'b1100;
  localparam logic [3:0] opMov = 4'b1101;

  // MOVAL R0,R0 used as the pipeline bubble
  localparam word_t opNop = 32'hE1A0_0000;

endpackage

`default_nettype wire

// File: armTb.sv
`timescale 1ns/1ns
`default_nettype none

module armTb;
  import armPkg::*;

  localparam int clkPeriod = 10;
  localparam int resetCycles = 4;
  localparam int imemWords = 64;
  localparam int drainCycles = 8;
  localparam int runCount = 9;
  localparam int runCycles = resetCycles + imemWords + drainCycles;
  localparam int marginCycles = 50;

  // ARM data processing opcodes
  localparam logic [3:0] encAnd = 4'b0000;
  localparam logic [3:0] encSub = 4'b0010;
  localparam logic [3:0] encAdd = 4'b0100;
  localparam logic [3:0] encOrr = 4'b1100;
  localparam logic [3:0] encMov = 4'b1101;

  logic   clk = 1'b0;
  logic   rstN;
  word_t  instruction;
  word_t  readData;
  word_t  pc;
  word_t  dataAddr;
  word_t  writeData;
  logic   writeEnable;

  word_t  imem [0:imemWords-1];
  word_t  dmem [0:63];
  int     progLen;
  integer seed = 91339;

  word_t  storeAddr [$];
  word_t  storeData [$];
  word_t  expAddr [$];
  word_t  expData [$];

  arm #(.resetPc(32'h0000_0000)) dut (
    .clk        (clk),
    .rstN       (rstN),
    .instruction(instruction),
    .readData   (readData),
    .pc         (pc),
    .dataAddr   (dataAddr),
    .writeData  (writeData),
    .writeEnable(writeEnable)
  );

  always #(clkPeriod / 2) clk = ~clk;

  function automatic word_t fetchWord(word_t addr);
    if (addr < word_t'(4 * progLen)) return imem[addr[7:2]];
    return opNop;
  endfunction

  // Addresses outside the 64 word array read back a pattern of the address
  function automatic word_t loadWord(word_t addr);
    if (addr[31:8] == 24'd0) return dmem[addr[7:2]];
    return addr ^ 32'h5A5A_5A5A;
  endfunction

  // Both memories answer the address of the current cycle
  always @(posedge clk) begin
    #1;
    instruction = fetchWord(pc);
    readData = loadWord(dataAddr);
  end

  // Store log and data memory update
  always @(negedge clk) begin
    if (rstN && writeEnable) begin
      storeAddr.push_back(dataAddr);
      storeData.push_back(writeData);
      if (dataAddr[31:8] == 24'd0) dmem[dataAddr[7:2]] = writeData;
    end
  end

  initial begin
    #(clkPeriod * (runCount * runCycles + marginCycles));
    $display("Watchdog expired after %0d cycles", runCount * runCycles + marginCycles);
    $display("Finished with errors");
    $fatal(1, "Run did not complete in time");
  end

  function automatic word_t randomWord();
    int r;
    r = $random(seed);
    return word_t'(r);
  endfunction

  function automatic logic [7:0] randomByte();
    int r;
    r = $random(seed);
    return r[7:0];
  endfunction

  function automatic word_t encDpImm(cond_t cond, logic [3:0] opcode, logic s,
                                     regAddr_t rn, regAddr_t rd, logic [7:0] imm8);
    return {cond, 2'b00, 1'b1, opcode, s, rn, rd, 4'h0, imm8};
  endfunction

  function automatic word_t encDpReg(cond_t cond, logic [3:0] opcode, logic s,
                                     regAddr_t rn, regAddr_t rd, regAddr_t rm);
    return {cond, 2'b00, 1'b0, opcode, s, rn, rd, 8'h00, rm};
  endfunction

  // Pre-indexed immediate offset, no writeback, word access
  function automatic word_t encMem(cond_t cond, logic load, regAddr_t rn, regAddr_t rd,
                                   int offset);
    logic        up;
    int          mag;
    logic [11:0] imm12;
    up = offset >= 0;
    mag = up ? offset : -offset;
    imm12 = mag[11:0];
    return {cond, 2'b01, 1'b0, 1'b1, up, 1'b0, 1'b0, load, rn, rd, imm12};
  endfunction

  // Offset counts words from the branch address plus 8
  function automatic word_t encBranch(cond_t cond, int fromIdx, int toIdx);
    int off;
    off = toIdx - fromIdx - 2;
    return {cond, 3'b101, 1'b0, off[23:0]};
  endfunction

  function automatic flags_t subFlags(word_t a, word_t b);
    word_t  diff;
    longint wide;
    logic   n;
    logic   z;
    logic   c;
    logic   v;
    diff = a - b;
    wide = longint'($signed(a)) - longint'($signed(b));
    n = diff[31];
    z = diff == 32'd0;
    // No borrow when a is not below b
    c = a >= b;
    // Signed difference does not fit in 32 bits
    v = wide != longint'($signed(diff));
    return {n, z, c, v};
  endfunction

  function automatic logic condHolds(cond_t cond, flags_t f);
    logic n;
    logic z;
    logic c;
    logic v;
    {n, z, c, v} = f;
    case (cond)
      EQ: return z;
      NE: return !z;
      CS: return c;
      CC: return !c;
      MI: return n;
      PL: return !n;
      VS: return v;
      VC: return !v;
      HI: return c && !z;
      LS: return !c || z;
      GE: return n == v;
      LT: return n != v;
      GT: return !z && (n == v);
      LE: return z || (n != v);
      default: return 1'b1;
    endcase
  endfunction

  task automatic failRun(string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic checkWord(string name, word_t actual, word_t expected);
    if (actual !== expected) begin
      failRun($sformatf("CHECK FAILED %s: got %h expected %h", name, actual, expected));
    end
  endtask

  task automatic checkBit(string name, logic actual, logic expected);
    if (actual !== expected) begin
      failRun($sformatf("CHECK FAILED %s: got %h expected %h", name, actual, expected));
    end
  endtask

  task automatic checkCount(string name, int actual, int expected);
    if (actual != expected) begin
      failRun($sformatf("CHECK FAILED %s: got %h expected %h", name, actual, expected));
    end
  endtask

  task automatic stepCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic clearProgram();
    progLen = 0;
    expAddr.delete();
    expData.delete();
  endtask

  task automatic emit(word_t w);
    if (progLen >= imemWords) begin
      failRun("Program does not fit in the instruction memory");
    end else begin
      imem[progLen[5:0]] = w;
      progLen++;
    end
  endtask

  task automatic nops(int n);
    repeat (n) emit(opNop);
  endtask

  task automatic expectStore(word_t addr, word_t data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  // No store may leave the core while reset is held
  task automatic resetDut();
    rstN = 1'b0;
    repeat (resetCycles) begin
      stepCycle();
      checkBit("writeEnable", writeEnable, 1'b0);
    end
    storeAddr.delete();
    storeData.delete();
    rstN = 1'b1;
  endtask

  task automatic runProgram();
    resetDut();
    repeat (progLen + drainCycles) stepCycle();
  endtask

  task automatic compareStores(string testName);
    for (int i = 0; i < expAddr.size(); i++) begin
      if (i >= storeAddr.size()) begin
        failRun($sformatf("%s: expected store %0d to address %h never happened",
                          testName, i, expAddr[i]));
      end
      checkWord($sformatf("%s store %0d dataAddr", testName, i), storeAddr[i], expAddr[i]);
      checkWord($sformatf("%s store %0d writeData", testName, i), storeData[i], expData[i]);
    end
    checkCount($sformatf("%s store count", testName), storeAddr.size(), expAddr.size());
  endtask

  // Stores are in flight when reset is asserted the second time
  task automatic testReset();
    clearProgram();
    for (int i = 0; i < 8; i++) begin
      emit(encMem(AL, 1'b0, 4'd15, 4'd15, 0));
    end
    resetDut();
    repeat (5) stepCycle();
    resetDut();
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      checkWord("pc", pc, word_t'(4 * i));
      // First store reaches the memory stage in the fourth cycle
      checkBit("writeEnable", writeEnable, i >= 3);
    end
    stepCycle();
    for (int i = 0; i < 5; i++) begin
      // R15 reads as the store's own address plus 8
      expectStore(word_t'(4 * i + 8), word_t'(4 * i + 8));
    end
    compareStores("reset");
    $display("Reset test done");
  endtask

  task automatic testDataProcessing();
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
    logic [7:0] d;
    word_t      wa;
    word_t      wb;
    clearProgram();
    a = randomByte();
    b = randomByte();
    c = randomByte();
    d = randomByte();
    wa = {24'd0, a};
    wb = {24'd0, b};
    emit(encDpImm(AL, encMov, 1'b0, 4'd0, 4'd1, a));
    emit(encDpImm(AL, encMov, 1'b0, 4'd0, 4'd2, b));
    emit(encDpImm(AL, encMov, 1'b0, 4'd0, 4'd13, 8'h80));
    nops(2);
    emit(encDpReg(AL, encAdd, 1'b0, 4'd1, 4'd3, 4'd2));
    emit(encDpReg(AL, encSub, 1'b0, 4'd1, 4'd4, 4'd2));
    emit(encDpReg(AL, encAnd, 1'b0, 4'd1, 4'd5, 4'd2));
    emit(encDpImm(AL, encOrr, 1'b0, 4'd1, 4'd6, c));
    emit(encDpImm(AL, encSub, 1'b0, 4'd2, 4'd7, d));
    emit(encDpReg(AL, encMov, 1'b0, 4'd0, 4'd8, 4'd2));
    emit(encMem(AL, 1'b0, 4'd13, 4'd3, 0));
    emit(encMem(AL, 1'b0, 4'd13, 4'd4, 4));
    emit(encMem(AL, 1'b0, 4'd13, 4'd5, -4));
    emit(encMem(AL, 1'b0, 4'd13, 4'd6, 16));
    emit(encMem(AL, 1'b0, 4'd13, 4'd7, -32));
    emit(encMem(AL, 1'b0, 4'd13, 4'd8, 124));
    runProgram();
    expectStore(32'h80, wa + wb);
    expectStore(32'h84, wa - wb);
    expectStore(32'h7C, wa & wb);
    expectStore(32'h90, wa | {24'd0, c});
    expectStore(32'h60, wb - {24'd0, d});
    expectStore(32'hFC, wb);
    compareStores("data processing");
    $display("Data processing test done");
  endtask

  task automatic testLoads();
    word_t upWord;
    word_t downWord;
    clearProgram();
    for (int i = 0; i < 64; i++) begin
      dmem[i[5:0]] = randomWord();
    end
    // 0x80 + 8 and 0x80 - 12
    upWord = dmem[34];
    downWord = dmem[29];
    emit(encDpImm(AL, encMov, 1'b0, 4'd0, 4'd13, 8'h80));
    nops(2);
    emit(encMem(AL, 1'b1, 4'd13, 4'd1, 8));
    emit(encMem(AL, 1'b1, 4'd13, 4'd2, -12));
    nops(2);
    emit(encMem(AL, 1'b0, 4'd13, 4'd1, 32));
    emit(encMem(AL, 1'b0, 4'd13, 4'd2, -64));
    runProgram();
    expectStore(32'hA0, upWord);
    expectStore(32'h40, downWord);
    compareStores("loads");
    $display("Load test done");
  endtask

  // One SUBS followed by a STR under each condition but AL
  task automatic runFlagPair(int k, word_t a, word_t b);
    flags_t     f;
    logic [7:0] marker;
    clearProgram();
    marker = 8'h10 + k[7:0];
    dmem[0] = a;
    dmem[1] = b;
    emit(encDpImm(AL, encMov, 1'b0, 4'd0, 4'd12, 8'h00));
    emit(encDpImm(AL, encMov, 1'b0, 4'd0, 4'd13, 8'h80));
    emit(encDpImm(AL, encMov, 1'b0, 4'd0, 4'd4, marker));
    emit(encMem(AL, 1'b1, 4'd12, 4'd1, 0));
    emit(encMem(AL, 1'b1, 4'd12, 4'd2, 4));
    nops(2);
    emit(encDpReg(AL, encSub, 1'b1, 4'd1, 4'd3, 4'd2));
    for (int i = 0; i < 14; i++) begin
      emit(encMem(cond_t'(i), 1'b0, 4'd13, 4'd4, 4 * i));
    end
    emit(encMem(AL, 1'b0, 4'd13, 4'd3, 64));
    runProgram();
    f = subFlags(a, b);
    for (int i = 0; i < 14; i++) begin
      if (condHolds(cond_t'(i), f)) expectStore(32'h80 + word_t'(4 * i), {24'd0, marker});
    end
    expectStore(32'hC0, a - b);
    compareStores($sformatf("flags pair %0d", k));
  endtask

  task automatic testFlags();
    word_t x;
    x = randomWord();
    runFlagPair(0, x, x);
    runFlagPair(1, 32'h8000_0000, 32'h0000_0001);
    runFlagPair(2, 32'h7FFF_FFFF, 32'hFFFF_FFFF);
    runFlagPair(3, 32'h0000_0005, 32'h0000_0009);
    runFlagPair(4, randomWord(), randomWord());
    $display("Flags and conditions test done");
  endtask

  task automatic testBranches();
    clearProgram();
    emit(encDpImm(AL, encMov, 1'b0, 4'd0, 4'd13, 8'h80));
    emit(encDpImm(AL, encMov, 1'b0, 4'd0, 4'd4, 8'h55));
    nops(2);
    // Z set for the conditional branches below
    emit(encDpReg(AL, encSub, 1'b1, 4'd4, 4'd5, 4'd4));
    emit(encBranch(AL, 5, 11));
    for (int i = 0; i < 5; i++) begin
      emit(encMem(AL, 1'b0, 4'd13, 4'd4, 4 * i));
    end
    emit(encMem(AL, 1'b0, 4'd13, 4'd4, 20));
    emit(encBranch(NE, 12, 20));
    emit(encMem(AL, 1'b0, 4'd13, 4'd4, 24));
    emit(encBranch(EQ, 14, 19));
    for (int i = 0; i < 4; i++) begin
      emit(encMem(AL, 1'b0, 4'd13, 4'd4, 28 + 4 * i));
    end
    emit(encMem(AL, 1'b0, 4'd13, 4'd4, 44));
    emit(encMem(AL, 1'b0, 4'd13, 4'd4, 48));
    runProgram();
    expectStore(32'h94, 32'h55);
    expectStore(32'h98, 32'h55);
    expectStore(32'hAC, 32'h55);
    expectStore(32'hB0, 32'h55);
    compareStores("branches");
    $display("Branch test done");
  endtask

  initial begin
    rstN = 1'b0;
    instruction = opNop;
    readData = 32'd0;
    progLen = 0;
    for (int i = 0; i < 64; i++) begin
      dmem[i[5:0]] = 32'hD0D0_0000 | word_t'(4 * i);
    end
    testReset();
    testDataProcessing();
    testLoads();
    testFlags();
    testBranches();
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: decode.sv
`timescale 1ns/1ns
`default_nettype none

module decode (
  input  logic             clk,
  input  logic             rstN,
  input  logic             flushE,
  input  armPkg::word_t    instrD,
  input  armPkg::word_t    pcPlus8D,
  input  logic             regWriteW,
  input  armPkg::regAddr_t destW,
  input  armPkg::word_t    resultW,
  output armPkg::aluOp_t   aluOpE,
  output logic             aluSrcE,
  output logic             setFlagsE,
  output logic             regWriteE,
  output logic             memWriteE,
  output logic             memToRegE,
  output logic             branchE,
  output armPkg::cond_t    condE,
  output armPkg::word_t    rdAE,
  output armPkg::word_t    rdBE,
  output armPkg::word_t    immE,
  output armPkg::regAddr_t destE
);
  import armPkg::*;

  logic       isDp;
  logic       isMem;
  logic       isBranch;
  logic [3:0] dpOpcode;
  logic       immBit;
  logic       sBit;
  logic       upBit;
  logic       loadBit;
  regAddr_t   rn;
  regAddr_t   rd;
  regAddr_t   rm;
  regAddr_t   addrA;
  regAddr_t   addrB;
  word_t      dataA;
  word_t      dataB;
  word_t      immD;
  aluOp_t     aluOpD;

  // Instruction classes from bits 27:26
  assign isDp     = instrD[27:26] == 2'b00;
  assign isMem    = instrD[27:26] == 2'b01;
  assign isBranch = instrD[27:26] == 2'b10;

  assign dpOpcode = instrD[24:21];
  assign immBit   = instrD[25];
  assign sBit     = instrD[20];
  assign upBit    = instrD[23];
  assign loadBit  = instrD[20];
  assign rn       = instrD[19:16];
  assign rd       = instrD[15:12];
  assign rm       = instrD[3:0];

  // Branches read R15 so the ALU forms pc+8 plus offset
  assign addrA = isBranch ? 4'hF : rn;
  // Stores read the data register on port B
  assign addrB = (isMem && !loadBit) ? rd : rm;

  regFile rf (
    .clk        (clk),
    .rstN       (rstN),
    .addrA      (addrA),
    .addrB      (addrB),
    .pcPlus8    (pcPlus8D),
    .writeEnable(regWriteW),
    .writeAddr  (destW),
    .writeData  (resultW),
    .dataA      (dataA),
    .dataB      (dataB)
  );

  always_comb begin
    aluOpD = aluAdd;
    if (isDp) begin
      case (dpOpcode)
        opAnd:   aluOpD = aluAnd;
        opSub:   aluOpD = aluSub;
        opAdd:   aluOpD = aluAdd;
        opOrr:   aluOpD = aluOrr;
        opMov:   aluOpD = aluMov;
        default: aluOpD = aluAdd;
      endcase
    end else if (isMem && !upBit) begin
      aluOpD = aluSub;
    end
  end

  always_comb begin
    if (isBranch) immD = {{6{instrD[23]}}, instrD[23:0], 2'b00};
    else if (isMem) immD = {20'd0, instrD[11:0]};
    else immD = {24'd0, instrD[7:0]};
  end

  // Decode/execute controls, bubble on reset or flush
  always_ff @(posedge clk) begin
    if (!rstN || flushE) begin
      setFlagsE <= 1'b0;
      regWriteE <= 1'b0;
      memWriteE <= 1'b0;
      memToRegE <= 1'b0;
      branchE   <= 1'b0;
      condE     <= AL;
    end else begin
      setFlagsE <= isDp && sBit;
      regWriteE <= isDp || (isMem && loadBit);
      memWriteE <= isMem && !loadBit;
      memToRegE <= isMem && loadBit;
      branchE   <= isBranch;
      condE     <= instrD[31:28];
    end
  end

  always_ff @(posedge clk) begin
    aluOpE  <= aluOpD;
    aluSrcE <= !isDp || immBit;
    rdAE    <= dataA;
    rdBE    <= dataB;
    immE    <= immD;
    destE   <= rd;
  end

endmodule

`default_nettype wire

// File: execute.sv
`timescale 1ns/1ns
`default_nettype none

module execute (
  input  logic             clk,
  input  logic             rstN,
  input  armPkg::aluOp_t   aluOpE,
  input  logic             aluSrcE,
  input  logic             setFlagsE,
  input  logic             regWriteE,
  input  logic             memWriteE,
  input  logic             memToRegE,
  input  logic             branchE,
  input  armPkg::cond_t    condE,
  input  armPkg::word_t    rdAE,
  input  armPkg::word_t    rdBE,
  input  armPkg::word_t    immE,
  input  armPkg::regAddr_t destE,
  output logic             branchTakenE,
  output armPkg::word_t    branchTargetE,
  output armPkg::word_t    aluOutM,
  output armPkg::word_t    writeDataM,
  output armPkg::regAddr_t destM,
  output logic             regWriteM,
  output logic             memWriteM,
  output logic             memToRegM
);
  import armPkg::*;

  flags_t      flags;
  flags_t      aluFlags;
  logic        flagN;
  logic        flagZ;
  logic        flagC;
  logic        flagV;
  word_t       srcB;
  word_t       aluResult;
  logic [32:0] sum;
  logic        carryOut;
  logic        overflow;
  logic        condPass;

  assign {flagN, flagZ, flagC, flagV} = flags;
  assign srcB = aluSrcE ? immE : rdBE;

  // Logic ops and MOV leave C and V alone, there is no shifter carry
  always_comb begin
    sum       = 33'd0;
    carryOut  = flagC;
    overflow  = flagV;
    aluResult = srcB;
    case (aluOpE)
      aluAdd: begin
        sum       = {1'b0, rdAE} + {1'b0, srcB};
        aluResult = sum[31:0];
        carryOut  = sum[32];
        overflow  = (rdAE[31] == srcB[31]) && (aluResult[31] != rdAE[31]);
      end
      aluSub: begin
        // Carry set means no borrow
        sum       = {1'b0, rdAE} + {1'b0, ~srcB} + 33'd1;
        aluResult = sum[31:0];
        carryOut  = sum[32];
        overflow  = (rdAE[31] != srcB[31]) && (aluResult[31] != rdAE[31]);
      end
      aluAnd:  aluResult = rdAE & srcB;
      aluOrr:  aluResult = rdAE | srcB;
      aluMov:  aluResult = srcB;
      default: aluResult = srcB;
    endcase
    aluFlags = {aluResult[31], aluResult == 32'd0, carryOut, overflow};
  end

  always_comb begin
    case (condE)
      EQ:      condPass = flagZ;
      NE:      condPass = !flagZ;
      CS:      condPass = flagC;
      CC:      condPass = !flagC;
      MI:      condPass = flagN;
      PL:      condPass = !flagN;
      VS:      condPass = flagV;
      VC:      condPass = !flagV;
      HI:      condPass = flagC && !flagZ;
      LS:      condPass = !flagC || flagZ;
      GE:      condPass = flagN == flagV;
      LT:      condPass = flagN != flagV;
      GT:      condPass = !flagZ && (flagN == flagV);
      LE:      condPass = flagZ || (flagN != flagV);
      AL:      condPass = 1'b1;
      default: condPass = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= 4'b0000;
    end else if (setFlagsE && condPass) begin
      flags <= aluFlags;
    end
  end

  // Base is R15 for a branch, so the ALU sum is the target
  assign branchTakenE  = branchE && condPass;
  assign branchTargetE = aluResult;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      regWriteM <= 1'b0;
      memWriteM <= 1'b0;
      memToRegM <= 1'b0;
    end else begin
      regWriteM <= regWriteE && condPass;
      memWriteM <= memWriteE && condPass;
      memToRegM <= memToRegE && condPass;
    end
  end

  always_ff @(posedge clk) begin
    aluOutM    <= aluResult;
    writeDataM <= rdBE;
    destM      <= destE;
  end

  loadStoreExclusive: assert property (@(posedge clk) disable iff (!rstN)
    !(memWriteM && memToRegM))
    else $error("load and store strobes both set");

endmodule

`default_nettype wire

// File: fetch.sv
`timescale 1ns/1ns
`default_nettype none

module fetch #(
  parameter armPkg::word_t resetPc = 32'h0000_0000
) (
  input  logic          clk,
  input  logic          rstN,
  input  logic          branchTakenE,
  input  armPkg::word_t branchTargetE,
  input  armPkg::word_t instruction,
  output armPkg::word_t pc,
  output armPkg::word_t instrD,
  output armPkg::word_t pcPlus8D
);
  import armPkg::*;

  // Program counter, redirected one edge after a taken branch
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= resetPc;
    end else if (branchTakenE) begin
      pc <= branchTargetE;
    end else begin
      pc <= pc + 32'd4;
    end
  end

  // Fetch/decode register, the fetched word is dropped on a flush
  always_ff @(posedge clk) begin
    if (!rstN || branchTakenE) begin
      instrD <= opNop;
    end else begin
      instrD <= instruction;
    end
  end

  // R15 value seen by the instruction in decode
  always_ff @(posedge clk) begin
    pcPlus8D <= pc + 32'd8;
  end

  pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

// File: memory.sv
`timescale 1ns/1ns
`default_nettype none

module memory (
  input  logic             clk,
  input  logic             rstN,
  input  armPkg::word_t    aluOutM,
  input  armPkg::word_t    writeDataM,
  input  armPkg::regAddr_t destM,
  input  logic             regWriteM,
  input  logic             memWriteM,
  input  logic             memToRegM,
  input  armPkg::word_t    readData,
  output armPkg::word_t    dataAddr,
  output armPkg::word_t    writeData,
  output logic             writeEnable,
  output logic             regWriteW,
  output armPkg::regAddr_t destW,
  output armPkg::word_t    resultW
);
  import armPkg::*;

  logic  memToRegW;
  word_t readDataW;
  word_t aluOutW;

  // Data memory is driven straight from the execute/memory register
  assign dataAddr    = aluOutM;
  assign writeData   = writeDataM;
  assign writeEnable = memWriteM;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      regWriteW <= 1'b0;
      memToRegW <= 1'b0;
    end else begin
      regWriteW <= regWriteM;
      memToRegW <= memToRegM;
    end
  end

  always_ff @(posedge clk) begin
    readDataW <= readData;
    aluOutW   <= aluOutM;
    destW     <= destM;
  end

  // Writeback select
  assign resultW = memToRegW ? readDataW : aluOutW;

endmodule

`default_nettype wire

// File: regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
  input  logic             clk,
  input  logic             rstN,
  input  armPkg::regAddr_t addrA,
  input  armPkg::regAddr_t addrB,
  input  armPkg::word_t    pcPlus8,
  input  logic             writeEnable,
  input  armPkg::regAddr_t writeAddr,
  input  armPkg::word_t    writeData,
  output armPkg::word_t    dataA,
  output armPkg::word_t    dataB
);
  import armPkg::*;

  // R0 to R14, R15 lives in fetch
  word_t regs [0:14];

  always_ff @(posedge clk) begin
    if (rstN && writeEnable && writeAddr != 4'hF) begin
      regs[writeAddr] <= writeData;
    end
  end

  // Write-through so writeback and decode can share a cycle
  always_comb begin
    if (addrA == 4'hF) dataA = pcPlus8;
    else if (writeEnable && writeAddr == addrA) dataA = writeData;
    else dataA = regs[addrA];
  end

  always_comb begin
    if (addrB == 4'hF) dataB = pcPlus8;
    else if (writeEnable && writeAddr == addrB) dataB = writeData;
    else dataB = regs[addrB];
  end

  noPcWrite: assert property (@(posedge clk) disable iff (!rstN)
    writeEnable |-> writeAddr != 4'hF)
    else $error("register write to R15");

endmodule

`default_nettype wire

// File: sim.f
armPkg.sv
fetch.sv
regFile.sv
decode.sv
execute.sv
memory.sv
arm.sv
armTb.sv
